//--- source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and program counter width.
`define CPU_XLEN 32

// architectural register file.
`define CPU_NUM_REGS 32
`define CPU_REG_BITS 5

// micro-op entries held in front of the execute unit.
`define CPU_IQ_DEPTH 4

// byte step between consecutive instructions.
`define CPU_PC_STEP 4

`endif

//--- source/isa_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package isa_pkg;

    typedef logic [`CPU_XLEN-1:0]     word_t;
    typedef logic [`CPU_REG_BITS-1:0] reg_idx_t;

    // only the two integer alu opcodes are legal here.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    // srl and sra share a code, bit 30 tells them apart.
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_e    funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        funct3_e     funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_type_t;

    // one instruction word, two views.
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- source/uop_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package uop_pkg;
    import isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // queue pointer and occupancy.
    typedef logic [$clog2(`CPU_IQ_DEPTH)-1:0]   iq_ptr_t;
    typedef logic [$clog2(`CPU_IQ_DEPTH+1)-1:0] iq_cnt_t;

    typedef struct packed {
        word_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        logic     use_imm;
    } uop_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    data;
    } complete_t;

endpackage

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module decoder
    import isa_pkg::*, uop_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rstn,
    input  wire logic   instr_valid,
    input  wire instr_u instr,
    output logic        uop_valid,
    output uop_t        uop,
    output logic        illegal
);

    word_t pc;
    word_t imm_sext;
    word_t imm_shamt;
    logic  legal;

    assign imm_sext  = {{(`CPU_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_shamt = {{(`CPU_XLEN-5){1'b0}}, instr.i.imm[4:0]};

    always_comb begin
        uop     = '0;
        uop.pc  = pc;
        uop.rs1 = instr.r.rs1;
        uop.rd  = instr.r.rd;
        legal   = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin
                legal   = 1'b1;
                uop.rs2 = instr.r.rs2;
                // funct7 bit 5 is instruction bit 30.
                case (instr.r.funct3)
                    F3_ADD:  uop.alu_op = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLL:  uop.alu_op = ALU_SLL;
                    F3_SLT:  uop.alu_op = ALU_SLT;
                    F3_SLTU: uop.alu_op = ALU_SLTU;
                    F3_XOR:  uop.alu_op = ALU_XOR;
                    F3_SRL:  uop.alu_op = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:   uop.alu_op = ALU_OR;
                    default: uop.alu_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                legal       = 1'b1;
                uop.use_imm = 1'b1;
                uop.imm     = imm_sext;
                case (instr.i.funct3)
                    F3_ADD:  uop.alu_op = ALU_ADD;
                    F3_SLL: begin
                        uop.alu_op = ALU_SLL;
                        uop.imm    = imm_shamt;
                    end
                    F3_SLT:  uop.alu_op = ALU_SLT;
                    F3_SLTU: uop.alu_op = ALU_SLTU;
                    F3_XOR:  uop.alu_op = ALU_XOR;
                    F3_SRL: begin
                        uop.alu_op = instr.i.imm[10] ? ALU_SRA : ALU_SRL;
                        uop.imm    = imm_shamt;
                    end
                    F3_OR:   uop.alu_op = ALU_OR;
                    default: uop.alu_op = ALU_AND;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    assign uop_valid = instr_valid & legal;

    // every strobe takes a pc, illegal ones too.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc      <= '0;
            illegal <= 1'b0;
        end else begin
            illegal <= instr_valid & ~legal;
            if (instr_valid) begin
                pc <= pc + `CPU_XLEN'(`CPU_PC_STEP);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module issue_queue
    import uop_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic uop_valid,
    input  wire uop_t uop,
    input  wire logic pop,
    output logic      head_valid,
    output uop_t      head,
    output logic      stall
);

    localparam iq_cnt_t DEPTH    = iq_cnt_t'(`CPU_IQ_DEPTH);
    localparam iq_ptr_t LAST_PTR = iq_ptr_t'(`CPU_IQ_DEPTH - 1);

    uop_t    entries [`CPU_IQ_DEPTH];
    iq_ptr_t wr_ptr;
    iq_ptr_t rd_ptr;
    iq_cnt_t count;
    iq_cnt_t count_next;
    logic    do_write;
    logic    do_pop;

    // a strobe into a full queue is dropped.
    assign do_write = uop_valid && (count != DEPTH);
    // pop is only raised against a valid head.
    assign do_pop   = pop;

    always_comb begin
        count_next = count;
        if (do_write && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_write) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            entries[wr_ptr] <= uop;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            stall  <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // full flag, registered.
            stall <= (count_next == DEPTH);
        end
    end

    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr];

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module execute_unit
    import isa_pkg::*, uop_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic head_valid,
    input  wire uop_t head,
    output logic      pop,
    output complete_t complete
);

    word_t    regs [`CPU_NUM_REGS];
    logic     hazard;
    logic     ex_valid;
    uop_t     ex_uop;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_opnd;
    word_t    alu_result;
    logic     wb_valid;
    word_t    wb_pc;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // x0 reads zero, a writeback in flight is forwarded.
    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_valid && (wb_rd == idx)) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    // hold the head while the execute stage still owes one of its sources.
    assign hazard = ex_valid &&
                    (((head.rs1 != '0) && (head.rs1 == ex_uop.rd)) ||
                     ((head.rs2 != '0) && (head.rs2 == ex_uop.rd)));
    assign pop    = head_valid && !hazard;

    always_ff @(posedge clk) begin
        if (pop) begin
            ex_uop <= head;
            ex_a   <= read_reg(head.rs1);
            ex_b   <= read_reg(head.rs2);
        end
    end

    assign ex_opnd = ex_uop.use_imm ? ex_uop.imm : ex_b;

    always_comb begin
        case (ex_uop.alu_op)
            ALU_ADD:  alu_result = ex_a + ex_opnd;
            ALU_SUB:  alu_result = ex_a - ex_opnd;
            ALU_SLL:  alu_result = ex_a << ex_opnd[4:0];
            ALU_SLT:  alu_result = word_t'($signed(ex_a) < $signed(ex_opnd));
            ALU_SLTU: alu_result = word_t'(ex_a < ex_opnd);
            ALU_XOR:  alu_result = ex_a ^ ex_opnd;
            ALU_SRL:  alu_result = ex_a >> ex_opnd[4:0];
            ALU_SRA:  alu_result = word_t'($signed(ex_a) >>> ex_opnd[4:0]);
            ALU_OR:   alu_result = ex_a | ex_opnd;
            default:  alu_result = ex_a & ex_opnd;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_pc   <= ex_uop.pc;
            wb_rd   <= ex_uop.rd;
            wb_data <= alu_result;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            ex_valid <= pop;
            wb_valid <= ex_valid;
        end
    end

    // register file, written in the completion cycle.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign complete.valid = wb_valid;
    assign complete.pc    = wb_pc;
    assign complete.rd    = wb_rd;
    assign complete.data  = wb_data;

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core
    import isa_pkg::*, uop_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rstn,
    input  wire logic   instr_valid,
    input  wire instr_u instr,
    output logic        stall,
    output logic        illegal,
    output complete_t   complete
);

    // decoder to queue.
    logic uop_valid;
    uop_t uop;

    // queue to execute unit.
    logic head_valid;
    uop_t head;
    logic pop;

    decoder u_decoder (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .uop_valid   (uop_valid),
        .uop         (uop),
        .illegal     (illegal)
    );

    issue_queue u_issue_queue (
        .clk        (clk),
        .rstn       (rstn),
        .uop_valid  (uop_valid),
        .uop        (uop),
        .pop        (pop),
        .head_valid (head_valid),
        .head       (head),
        .stall      (stall)
    );

    execute_unit u_execute_unit (
        .clk        (clk),
        .rstn       (rstn),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .complete   (complete)
    );

endmodule

`default_nettype wire

//--- dv/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core_tb
    import isa_pkg::*, uop_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int N_TBL           = 38;
    localparam int N_RAND          = 64;
    localparam int WATCHDOG_CYCLES = (N_TBL + N_RAND) * 10 + 3;

    typedef struct packed {
        logic [31:0] word;
        logic        ill;
        word_t       data;
    } vec_t;

    logic      clk;
    logic      rstn;
    logic      instr_valid;
    instr_u    instr;
    logic      stall;
    logic      illegal;
    complete_t complete;

    vec_t        tbl [N_TBL];
    int          tbl_len;
    complete_t   exp_q [$];
    word_t       model_regs [`CPU_NUM_REGS];
    word_t       model_pc;
    logic [31:0] rng_state;
    logic        drive_ill;
    logic        ill_due;
    logic        saw_stall;

    cpu_core dut (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .illegal     (illegal),
        .complete    (complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_complete(input complete_t got, input complete_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf(
                {"MISMATCH at %0t ns: complete got pc=%h rd=%0d data=%h, ",
                 "expected pc=%h rd=%0d data=%h"},
                $time, got.pc, got.rd, got.data, exp.pc, exp.rd, exp.data));
        end
    endtask

    task automatic check_illegal(input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH at %0t ns: illegal got %b, expected %b",
                                    $time, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH at %0t ns: %s got %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // legal op or op-imm word on registers x0..x7 so dependencies are frequent.
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        r = next_rand();
        if (r[0]) begin
            return r_word(r[1] ? 7'h20 : 7'h00, {2'b00, r[10:8]}, {2'b00, r[7:5]},
                          r[13:11], {2'b00, r[4:2]});
        end
        return i_word(r[25:14], {2'b00, r[7:5]}, r[13:11], {2'b00, r[4:2]});
    endfunction

    // rv32i semantics on the model register file.
    function automatic word_t ref_exec(input logic [31:0] w);
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        logic       is_r;
        is_r = (w[6:0] == 7'b0110011);
        a    = model_regs[w[19:15]];
        b    = is_r ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh   = b[4:0];
        case (w[14:12])
            3'd0: return (is_r && w[30]) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return w[30] ? word_t'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_vec(input logic [31:0] word, input logic ill, input word_t data);
        tbl[tbl_len] = '{word, ill, data};
        tbl_len      = tbl_len + 1;
    endtask

    task automatic load_table();
        tbl_len = 0;
        add_vec(i_word(12'd5,   5'd0, 3'd0, 5'd1),          1'b0, 32'h0000_0005);
        add_vec(i_word(12'hFFD, 5'd0, 3'd0, 5'd2),          1'b0, 32'hFFFF_FFFD);
        // register-register, sub against add and mixed signs.
        add_vec(r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3),      1'b0, 32'h0000_0002);
        add_vec(r_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd4),      1'b0, 32'h0000_0008);
        add_vec(r_word(7'h20, 5'd1, 5'd2, 3'd0, 5'd5),      1'b0, 32'hFFFF_FFF8);
        add_vec(r_word(7'h00, 5'd1, 5'd2, 3'd2, 5'd6),      1'b0, 32'h0000_0001);
        add_vec(r_word(7'h00, 5'd1, 5'd2, 3'd3, 5'd7),      1'b0, 32'h0000_0000);
        add_vec(r_word(7'h00, 5'd1, 5'd1, 3'd1, 5'd8),      1'b0, 32'h0000_00A0);
        add_vec(r_word(7'h00, 5'd1, 5'd5, 3'd5, 5'd9),      1'b0, 32'h07FF_FFFF);
        add_vec(r_word(7'h20, 5'd1, 5'd5, 3'd5, 5'd10),     1'b0, 32'hFFFF_FFFF);
        add_vec(r_word(7'h00, 5'd2, 5'd1, 3'd4, 5'd11),     1'b0, 32'hFFFF_FFF8);
        add_vec(r_word(7'h00, 5'd2, 5'd1, 3'd6, 5'd12),     1'b0, 32'hFFFF_FFFD);
        add_vec(r_word(7'h00, 5'd2, 5'd1, 3'd7, 5'd13),     1'b0, 32'h0000_0005);
        // register-immediate, sign extension and shift amounts.
        add_vec(i_word(12'd1,   5'd2, 3'd2, 5'd14),         1'b0, 32'h0000_0001);
        add_vec(i_word(12'hFFF, 5'd1, 3'd3, 5'd15),         1'b0, 32'h0000_0001);
        add_vec(i_word(12'hFFF, 5'd1, 3'd4, 5'd16),         1'b0, 32'hFFFF_FFFA);
        add_vec(i_word(12'h0F0, 5'd1, 3'd6, 5'd17),         1'b0, 32'h0000_00F5);
        add_vec(i_word(12'h7F0, 5'd2, 3'd7, 5'd18),         1'b0, 32'h0000_07F0);
        add_vec(i_word(12'd28,  5'd1, 3'd1, 5'd19),         1'b0, 32'h5000_0000);
        add_vec(i_word(12'd4,   5'd5, 3'd5, 5'd20),         1'b0, 32'h0FFF_FFFF);
        add_vec(i_word(12'h402, 5'd5, 3'd5, 5'd21),         1'b0, 32'hFFFF_FFFE);
        add_vec(i_word(12'h023, 5'd1, 3'd1, 5'd22),         1'b0, 32'h0000_0028);
        // x0 as destination, then as source.
        add_vec(i_word(12'd7,   5'd1, 3'd0, 5'd0),          1'b0, 32'h0000_000C);
        add_vec(r_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd23),     1'b0, 32'h0000_0005);
        add_vec(32'h0000_0063,                              1'b1, 32'h0000_0000);
        // dependent burst, longer than the queue.
        for (int k = 1; k <= 8; k++) begin
            add_vec(i_word(12'd1, 5'd24, 3'd0, 5'd24),      1'b0, word_t'(k));
        end
        add_vec(r_word(7'h00, 5'd24, 5'd24, 3'd0, 5'd25),   1'b0, 32'h0000_0010);
        add_vec(r_word(7'h20, 5'd24, 5'd25, 3'd0, 5'd26),   1'b0, 32'h0000_0008);
        add_vec(32'h0000_0003,                              1'b1, 32'h0000_0000);
        add_vec(r_word(7'h00, 5'd2, 5'd1, 3'd2, 5'd27),     1'b0, 32'h0000_0000);
        add_vec(r_word(7'h00, 5'd2, 5'd1, 3'd3, 5'd28),     1'b0, 32'h0000_0001);
    endtask

    // one strobe, entered and left on a falling edge.
    task automatic send(input logic [31:0] word, input logic ill, input word_t data);
        complete_t rec;
        while (stall === 1'b1) begin
            @(negedge clk);
        end
        instr_valid = 1'b1;
        instr       = word;
        drive_ill   = ill;
        if (!ill) begin
            rec.valid = 1'b1;
            rec.pc    = model_pc;
            rec.rd    = word[11:7];
            rec.data  = data;
            exp_q.push_back(rec);
            if (word[11:7] != 5'd0) begin
                model_regs[word[11:7]] = data;
            end
        end
        model_pc = model_pc + `CPU_PC_STEP;
        @(negedge clk);
        instr_valid = 1'b0;
        drive_ill   = 1'b0;
    endtask

    // illegal pulse is due one cycle after an illegal strobe.
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ill_due <= 1'b0;
        end else begin
            ill_due <= instr_valid && drive_ill;
        end
    end

    always @(negedge clk) begin
        if (rstn) begin
            if (stall === 1'b1) begin
                saw_stall = 1'b1;
            end
            check_illegal(illegal, ill_due);
            if (complete.valid !== 1'b0) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("completion reported with no instruction outstanding");
                end else begin
                    check_complete(complete, exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("timeout: completions stopped arriving before all results were seen");
    end

    initial begin : stimulus
        logic [31:0] w;
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        drive_ill   = 1'b0;
        saw_stall   = 1'b0;
        model_pc    = '0;
        rng_state   = 32'd5226;
        for (int r = 0; r < `CPU_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        load_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_flag("stall", stall, 1'b0);
        check_flag("illegal", illegal, 1'b0);
        check_flag("complete.valid", complete.valid, 1'b0);
        for (int i = 0; i < N_TBL; i++) begin
            send(tbl[i].word, tbl[i].ill, tbl[i].data);
        end
        for (int i = 0; i < N_RAND; i++) begin
            w = random_instr();
            send(w, 1'b0, ref_exec(w));
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // idle cycles to catch stray pulses.
        repeat (4) @(negedge clk);
        if (!saw_stall) begin
            stop_on_error("stall never rose during the dependent bursts");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- cpu_core.f
+incdir+source
source/isa_pkg.sv
source/uop_pkg.sv
source/decoder.sv
source/issue_queue.sv
source/execute_unit.sv
source/cpu_core.sv
dv/cpu_core_tb.sv

//--- Makefile
# Verilator simulation of the cpu_core testbench.
# Any variable can be overridden on the command line, e.g. make simulate OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: simulate clean

# pass only when the testbench prints its pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
